//--- rtl/domain_arbiter.sv
// Round-robin merge of the normal and secure producer ports
// Tags each forwarded message with the port it came from

`timescale 1ns/1ps

module domain_arbiter (
  input  logic               clk,
  input  logic               reset,

  // Port 0, normal domain
  input  logic               in0_val,
  output logic               in0_rdy,
  input  msgq_pkg::msg_t     in0_msg,

  // Port 1, secure domain
  input  logic               in1_val,
  output logic               in1_rdy,
  input  msgq_pkg::msg_t     in1_msg,

  // Merged stream towards the queue
  msgq_if.producer           out
);

  // ------------------------------------------------------------
  // Selection
  // ------------------------------------------------------------

  // Port favored when both are valid, 0 after reset
  msgq_pkg::domain_t prio;
  // Port granted this cycle, doubles as the domain tag
  msgq_pkg::domain_t sel;
  logic              xfer;

  always_comb begin
    if (in0_val && in1_val) begin
      // Contention goes to the favored port
      sel = prio;
    end else begin
      // Lone requester wins, port 0 when idle
      sel = in1_val;
    end
  end

  // ------------------------------------------------------------
  // Forwarding
  // ------------------------------------------------------------

  assign out.val      = in0_val || in1_val;
  assign out.msg_data = sel ? in1_msg : in0_msg;
  assign out.domain   = sel;

  // Only the granted port sees the queue's ready
  assign in0_rdy = in0_val && (sel == 1'b0) && out.rdy;
  assign in1_rdy = in1_val && (sel == 1'b1) && out.rdy;

  assign xfer = out.val && out.rdy;

  // ------------------------------------------------------------
  // Priority update
  // ------------------------------------------------------------

  // Favor the port that was not served after every transfer
  always_ff @(posedge clk) begin
    if (!reset) begin
      prio <= 1'b0;
    end else if (xfer) begin
      prio <= ~sel;
    end
  end

endmodule

//--- rtl/msgq_if.sv
// Valid/ready message channel with domain tag
// Producer and consumer modports

`timescale 1ns/1ps

interface msgq_if;

  // ------------------------------------------------------------
  // Channel signals
  // ------------------------------------------------------------

  // Producer has a message this cycle
  logic               val;
  // Message payload, held stable while val waits for rdy
  msgq_pkg::msg_t     msg_data;
  // Domain the message belongs to
  msgq_pkg::domain_t  domain;
  // Consumer can take a message this cycle
  logic               rdy;

  // ------------------------------------------------------------
  // Modports
  // ------------------------------------------------------------

  // Side that sends messages
  modport producer (
    output val,
    output msg_data,
    output domain,
    input  rdy
  );

  // Side that takes messages
  modport consumer (
    input  val,
    input  msg_data,
    input  domain,
    output rdy
  );

endinterface

//--- rtl/msgq_pkg.sv
// Shared constants and typedefs for the domain-tagged message queue
// Queue depth, message width, pointer and free-count widths

package msgq_pkg;

  // ------------------------------------------------------------
  // Sizing
  // ------------------------------------------------------------

  // Number of queue entries
  localparam int NUM_MSGS  = 4;

  // Pointer and address width, enough to index every entry
  localparam int ADDR_BITS = $clog2(NUM_MSGS);

  // Message payload width
  localparam int MSG_BITS  = 32;

  // ------------------------------------------------------------
  // Types
  // ------------------------------------------------------------

  // Message payload
  typedef logic [MSG_BITS-1:0]  msg_t;

  // Domain tag, 0 for normal and 1 for secure
  typedef logic                 domain_t;

  // Register file address and queue pointer
  typedef logic [ADDR_BITS-1:0] addr_t;

  // Free-entry count, one bit wider so it can reach NUM_MSGS
  typedef logic [ADDR_BITS:0]   count_t;

endpackage

//--- rtl/msgq_top.sv
// Top level of the domain-tagged message queue subsystem
// Arbiter feeding the tagged queue, plain ports at the boundary

`timescale 1ns/1ps

module msgq_top (
  input  logic               clk,
  input  logic               reset,

  // Normal domain producer
  input  logic               in0_val,
  output logic               in0_rdy,
  input  msgq_pkg::msg_t     in0_msg,

  // Secure domain producer
  input  logic               in1_val,
  output logic               in1_rdy,
  input  msgq_pkg::msg_t     in1_msg,

  // Consumer side
  output logic               out_val,
  input  logic               out_rdy,
  output msgq_pkg::msg_t     out_msg,
  output msgq_pkg::domain_t  out_domain,

  // Entries still available in the queue
  output msgq_pkg::count_t   num_free_entries
);

  // ------------------------------------------------------------
  // Internal channels
  // ------------------------------------------------------------

  // Arbiter output into the queue
  msgq_if arb_to_q ();
  // Queue output, broken out onto plain ports below
  msgq_if q_out ();

  // ------------------------------------------------------------
  // Instances
  // ------------------------------------------------------------

  domain_arbiter arb (
    .clk     (clk),
    .reset   (reset),
    .in0_val (in0_val),
    .in0_rdy (in0_rdy),
    .in0_msg (in0_msg),
    .in1_val (in1_val),
    .in1_rdy (in1_rdy),
    .in1_msg (in1_msg),
    .out     (arb_to_q.producer)
  );

  tagged_queue queue (
    .clk              (clk),
    .reset            (reset),
    .enq              (arb_to_q.consumer),
    .deq              (q_out.producer),
    .num_free_entries (num_free_entries)
  );

  // Output channel to top-level ports
  assign out_val    = q_out.val;
  assign out_msg    = q_out.msg_data;
  assign out_domain = q_out.domain;
  assign q_out.rdy  = out_rdy;

endmodule

//--- rtl/queue_ctrl.sv
// Control logic for the multi-entry message queue
// Enqueue and dequeue pointers, full flag, handshake and free count

`timescale 1ns/1ps

module queue_ctrl (
  input  logic                clk,
  input  logic                reset,

  // Enqueue side
  input  logic                enq_val,
  output logic                enq_rdy,

  // Dequeue side
  output logic                deq_val,
  input  logic                deq_rdy,

  // Register file control
  output logic                write_en,
  output msgq_pkg::addr_t     write_addr,
  output msgq_pkg::addr_t     read_addr,

  // Entries still available
  output msgq_pkg::count_t    num_free_entries
);

  // ------------------------------------------------------------
  // State
  // ------------------------------------------------------------

  msgq_pkg::addr_t  enq_ptr;
  msgq_pkg::addr_t  deq_ptr;
  // Tells a full queue apart from an empty one when pointers match
  logic             full;

  logic             do_enq;
  logic             do_deq;
  logic             empty;

  // Pointer increments, computed one bit wider to catch the wrap
  msgq_pkg::count_t enq_plus1;
  msgq_pkg::count_t deq_plus1;
  msgq_pkg::addr_t  enq_ptr_inc;
  msgq_pkg::addr_t  deq_ptr_inc;

  // ------------------------------------------------------------
  // Handshake
  // ------------------------------------------------------------

  // Transfers happen only when val and rdy are both high
  assign do_enq = enq_val && enq_rdy;
  assign do_deq = deq_val && deq_rdy;

  assign empty  = !full && (enq_ptr == deq_ptr);

  // Ready from the full flag alone, no dequeue look-through
  assign enq_rdy = !full;
  // Valid from the stored state alone, no bypass
  assign deq_val = !empty;

  // Write the slot under the enqueue pointer on every enqueue
  assign write_en   = do_enq;
  assign write_addr = enq_ptr;
  assign read_addr  = deq_ptr;

  // ------------------------------------------------------------
  // Pointer update
  // ------------------------------------------------------------

  // Wrap at NUM_MSGS so depths that are not a power of two work
  assign enq_plus1   = {1'b0, enq_ptr} + 1'b1;
  assign deq_plus1   = {1'b0, deq_ptr} + 1'b1;
  assign enq_ptr_inc = (enq_plus1 == msgq_pkg::count_t'(msgq_pkg::NUM_MSGS)) ?
                       '0 : enq_plus1[msgq_pkg::ADDR_BITS-1:0];
  assign deq_ptr_inc = (deq_plus1 == msgq_pkg::count_t'(msgq_pkg::NUM_MSGS)) ?
                       '0 : deq_plus1[msgq_pkg::ADDR_BITS-1:0];

  always_ff @(posedge clk) begin
    if (!reset) begin
      enq_ptr <= '0;
      deq_ptr <= '0;
      full    <= 1'b0;
    end else begin
      if (do_enq) begin
        enq_ptr <= enq_ptr_inc;
      end
      if (do_deq) begin
        deq_ptr <= deq_ptr_inc;
      end
      // Fills when an enqueue alone catches up with the dequeue pointer
      if (do_enq && !do_deq && (enq_ptr_inc == deq_ptr)) begin
        full <= 1'b1;
      end else if (do_deq && full) begin
        full <= 1'b0;
      end
    end
  end

  // ------------------------------------------------------------
  // Free-entry count
  // ------------------------------------------------------------

  always_comb begin
    if (full) begin
      num_free_entries = '0;
    end else if (empty) begin
      num_free_entries = msgq_pkg::count_t'(msgq_pkg::NUM_MSGS);
    end else if (enq_ptr > deq_ptr) begin
      // Stored entries sit between the pointers without a wrap
      num_free_entries = msgq_pkg::count_t'(msgq_pkg::NUM_MSGS)
                       - msgq_pkg::count_t'(enq_ptr - deq_ptr);
    end else begin
      // Enqueue pointer has wrapped, so the gap is the free space
      num_free_entries = msgq_pkg::count_t'(deq_ptr - enq_ptr);
    end
  end

endmodule

//--- rtl/queue_store.sv
// Register file for the message queue
// One write port and one combinational read port for message and tag

`timescale 1ns/1ps

module queue_store (
  input  logic               clk,

  // Write port
  input  logic               write_en,
  input  msgq_pkg::addr_t    write_addr,
  input  msgq_pkg::msg_t     write_data,
  input  msgq_pkg::domain_t  write_domain,

  // Read port
  input  msgq_pkg::addr_t    read_addr,
  output msgq_pkg::msg_t     read_data,
  output msgq_pkg::domain_t  read_domain
);

  // ------------------------------------------------------------
  // Storage
  // ------------------------------------------------------------

  // Payload per entry
  msgq_pkg::msg_t    msg_mem [msgq_pkg::NUM_MSGS];
  // Domain tag per entry written alongside the payload
  msgq_pkg::domain_t tag_mem [msgq_pkg::NUM_MSGS];

  // Synchronous write of payload and tag
  always_ff @(posedge clk) begin
    if (write_en) begin
      msg_mem[write_addr] <= write_data;
      tag_mem[write_addr] <= write_domain;
    end
  end

  // ------------------------------------------------------------
  // Read
  // ------------------------------------------------------------

  // Head entry shows up in the same cycle deq_val is high
  assign read_data   = msg_mem[read_addr];
  assign read_domain = tag_mem[read_addr];

endmodule

//--- rtl/tagged_queue.sv
// Domain-tagged message queue
// Controller and register file joined behind two valid/ready channels

`timescale 1ns/1ps

module tagged_queue (
  input  logic              clk,
  input  logic              reset,

  // Incoming messages
  msgq_if.consumer          enq,

  // Outgoing messages
  msgq_if.producer          deq,

  // Entries still available
  output msgq_pkg::count_t  num_free_entries
);

  // ------------------------------------------------------------
  // Controller to storage
  // ------------------------------------------------------------

  logic            write_en;
  msgq_pkg::addr_t write_addr;
  msgq_pkg::addr_t read_addr;

  // Handshake side, val and rdy only
  queue_ctrl ctrl (
    .clk              (clk),
    .reset            (reset),
    .enq_val          (enq.val),
    .enq_rdy          (enq.rdy),
    .deq_val          (deq.val),
    .deq_rdy          (deq.rdy),
    .write_en         (write_en),
    .write_addr       (write_addr),
    .read_addr        (read_addr),
    .num_free_entries (num_free_entries)
  );

  // Data side, payload and tag travel together per entry
  queue_store store (
    .clk          (clk),
    .write_en     (write_en),
    .write_addr   (write_addr),
    .write_data   (enq.msg_data),
    .write_domain (enq.domain),
    .read_addr    (read_addr),
    .read_data    (deq.msg_data),
    .read_domain  (deq.domain)
  );

endmodule

//--- src.f
rtl/msgq_pkg.sv
rtl/msgq_if.sv
rtl/queue_ctrl.sv
rtl/queue_store.sv
rtl/tagged_queue.sv
rtl/domain_arbiter.sv
rtl/msgq_top.sv
verif/tb_msgq.sv

//--- verif/tb_msgq.sv
// Testbench for the domain-tagged message queue subsystem
// Clock, reset, LFSR stimulus, scoreboard model and concurrent assertions

`timescale 1ns/1ps

module tb_msgq;

  // ------------------------------------------------------------
  // Run constants
  // ------------------------------------------------------------

  localparam int          RESET_CYCLES   = 16;
  localparam int          RAND_CYCLES    = 1000;
  localparam logic [31:0] LFSR_SEED      = 32'h30ed;
  // Two resets plus tests 1 to 4 and the random traffic with its drain
  localparam int          TEST_LEN_SUM   = 2 * RESET_CYCLES + 10 + 80 + 40 + 40
                                         + RAND_CYCLES + 300;
  localparam int          TIMEOUT_CYCLES = 2 * TEST_LEN_SUM;

  logic                clk = 1'b0;
  logic                reset;
  logic                in0_val;
  logic                in0_rdy;
  msgq_pkg::msg_t      in0_msg;
  logic                in1_val;
  logic                in1_rdy;
  msgq_pkg::msg_t      in1_msg;
  logic                out_val;
  logic                out_rdy;
  msgq_pkg::msg_t      out_msg;
  msgq_pkg::domain_t   out_domain;
  msgq_pkg::count_t    num_free_entries;

  // Expected messages in arrival order with the port they came in on
  msgq_pkg::msg_t      exp_msg [16];
  msgq_pkg::domain_t   exp_dom [16];
  logic [3:0]          rd_idx;
  logic [3:0]          wr_idx;
  int                  model_count;
  // Port the arbiter should favor next
  logic                fav_port;
  // Input transfers seen at the last rising edge
  logic                took0;
  logic                took1;

  msgq_pkg::msg_t      head_msg;
  msgq_pkg::domain_t   head_dom;
  logic                exp_rdy0;
  logic                exp_rdy1;

  logic [31:0]         lfsr_state;
  string               cur_test;
  int                  err_count;
  int                  err_at_start;
  int                  pass_tests;
  int                  fail_tests;
  int                  cycle_count;

  always #50 clk = ~clk;

  msgq_top UUT (
    .clk              (clk),
    .reset            (reset),
    .in0_val          (in0_val),
    .in0_rdy          (in0_rdy),
    .in0_msg          (in0_msg),
    .in1_val          (in1_val),
    .in1_rdy          (in1_rdy),
    .in1_msg          (in1_msg),
    .out_val          (out_val),
    .out_rdy          (out_rdy),
    .out_msg          (out_msg),
    .out_domain       (out_domain),
    .num_free_entries (num_free_entries)
  );

  // ------------------------------------------------------------
  // Scoreboard model
  // ------------------------------------------------------------

  assign head_msg = exp_msg[rd_idx];
  assign head_dom = exp_dom[rd_idx];

  // Lone requester or favored port gets the grant unless the queue is full
  assign exp_rdy0 = in0_val && (model_count < msgq_pkg::NUM_MSGS) && (!in1_val || !fav_port);
  assign exp_rdy1 = in1_val && (model_count < msgq_pkg::NUM_MSGS) && (!in0_val || fav_port);

  always @(posedge clk) begin : scoreboard
    int         cnt;
    logic [3:0] wr;
    logic [3:0] rd;
    if (!reset) begin
      model_count <= 0;
      rd_idx      <= '0;
      wr_idx      <= '0;
      fav_port    <= 1'b0;
      took0       <= 1'b0;
      took1       <= 1'b0;
    end else begin
      cnt = model_count;
      wr  = wr_idx;
      rd  = rd_idx;
      // Pop before push so a new message is never the head in its own cycle
      if (out_val && out_rdy && cnt > 0) begin
        rd  = rd + 1'b1;
        cnt = cnt - 1;
      end
      if (in0_val && in0_rdy) begin
        exp_msg[wr] <= in0_msg;
        exp_dom[wr] <= 1'b0;
        wr  = wr + 1'b1;
        cnt = cnt + 1;
        fav_port <= 1'b1;
      end
      if (in1_val && in1_rdy) begin
        exp_msg[wr] <= in1_msg;
        exp_dom[wr] <= 1'b1;
        wr  = wr + 1'b1;
        cnt = cnt + 1;
        fav_port <= 1'b0;
      end
      model_count <= cnt;
      wr_idx      <= wr;
      rd_idx      <= rd;
      took0       <= in0_val && in0_rdy;
      took1       <= in1_val && in1_rdy;
    end
  end

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------

  // Output message and tag follow the expected order
  assert property (@(posedge clk) disable iff (!reset)
    out_val && out_rdy |-> out_msg == head_msg)
  else begin
    $display("ERR %s: out_msg expected %h actual %h", cur_test,
             $sampled(head_msg), $sampled(out_msg));
    err_count++;
  end

  assert property (@(posedge clk) disable iff (!reset)
    out_val && out_rdy |-> out_domain == head_dom)
  else begin
    $display("ERR %s: out_domain expected %0d actual %0d", cur_test,
             $sampled(head_dom), $sampled(out_domain));
    err_count++;
  end

  assert property (@(posedge clk) disable iff (!reset)
    int'(num_free_entries) == msgq_pkg::NUM_MSGS - model_count)
  else begin
    $display("ERR %s: num_free_entries expected %0d actual %0d", cur_test,
             msgq_pkg::NUM_MSGS - $sampled(model_count), $sampled(num_free_entries));
    err_count++;
  end

  assert property (@(posedge clk) disable iff (!reset) !in0_val |-> !in0_rdy)
  else begin
    $display("%s: in0_rdy is high while in0_val is low", cur_test);
    err_count++;
  end

  assert property (@(posedge clk) disable iff (!reset) !in1_val |-> !in1_rdy)
  else begin
    $display("%s: in1_rdy is high while in1_val is low", cur_test);
    err_count++;
  end

  assert property (@(posedge clk) disable iff (!reset)
    model_count == msgq_pkg::NUM_MSGS |-> !in0_rdy && !in1_rdy)
  else begin
    $display("%s: an input rdy is high while the queue holds every entry", cur_test);
    err_count++;
  end

  // Round-robin grant goes to the favored port and holds the other off
  assert property (@(posedge clk) disable iff (!reset) in0_rdy == exp_rdy0)
  else begin
    $display("ERR %s: in0_rdy expected %b actual %b", cur_test,
             $sampled(exp_rdy0), $sampled(in0_rdy));
    err_count++;
  end

  assert property (@(posedge clk) disable iff (!reset) in1_rdy == exp_rdy1)
  else begin
    $display("ERR %s: in1_rdy expected %b actual %b", cur_test,
             $sampled(exp_rdy1), $sampled(in1_rdy));
    err_count++;
  end

  // Valid only when something is stored and never in the enqueue cycle
  assert property (@(posedge clk) disable iff (!reset) out_val == (model_count != 0))
  else begin
    $display("ERR %s: out_val expected %b actual %b", cur_test,
             $sampled(model_count) != 0, $sampled(out_val));
    err_count++;
  end

  assert property (@(posedge clk) disable iff (!reset)
    out_val && !out_rdy |=> out_val && $stable(out_msg) && $stable(out_domain))
  else begin
    $display("%s: queue output dropped or changed a message before it was taken", cur_test);
    err_count++;
  end

  // ------------------------------------------------------------
  // Stimulus helpers
  // ------------------------------------------------------------

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  // Called on a falling edge or at time zero
  task automatic apply_reset();
    reset = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b1;
  endtask

  // Offer one message on a port and hold it until the transfer
  task automatic push_msg(input logic port, input msgq_pkg::msg_t data);
    if (port) begin
      in1_val = 1'b1;
      in1_msg = data;
    end else begin
      in0_val = 1'b1;
      in0_msg = data;
    end
    @(negedge clk);
    while (!(port ? took1 : took0)) @(negedge clk);
    if (port) in1_val = 1'b0;
    else in0_val = 1'b0;
  endtask

  task automatic wait_drained();
    while (model_count != 0) @(negedge clk);
  endtask

  task automatic start_test(input string name);
    cur_test     = name;
    err_at_start = err_count;
  endtask

  task automatic finish_test();
    if (err_count == err_at_start) begin
      pass_tests++;
      $display("test %s: ok", cur_test);
    end else begin
      fail_tests++;
      $display("test %s: %0d errors", cur_test, err_count - err_at_start);
    end
  endtask

  // ------------------------------------------------------------
  // Tests
  // ------------------------------------------------------------

  // Idle after reset with the queue empty and all entries free
  task automatic check_reset_state();
    start_test("reset_state");
    repeat (8) @(negedge clk);
    finish_test();
  endtask

  task automatic single_domain_order();
    start_test("single_domain_order");
    out_rdy = 1'b1;
    for (int i = 0; i < 8; i++) push_msg(1'b0, 32'h2000_0000 + i);
    for (int i = 0; i < 8; i++) push_msg(1'b1, 32'h2100_0000 + i);
    wait_drained();
    finish_test();
  endtask

  // Four accepted and a fifth held off until the consumer drains
  task automatic fill_and_drain();
    start_test("fill_back_pressure");
    out_rdy = 1'b0;
    for (int i = 0; i < 4; i++) push_msg(1'b0, 32'h3000_0000 + i);
    in0_val = 1'b1;
    in0_msg = 32'h3000_0004;
    repeat (6) @(negedge clk);
    // Fifth message gets in the cycle after the first dequeue
    out_rdy = 1'b1;
    while (!took0) @(negedge clk);
    in0_val = 1'b0;
    wait_drained();
    finish_test();
  endtask

  task automatic round_robin_merge();
    int n0;
    int n1;
    start_test("round_robin_merge");
    n0 = 0;
    n1 = 0;
    // Fresh reset so port 0 is favored first
    apply_reset();
    out_rdy = 1'b1;
    in0_val = 1'b1;
    in1_val = 1'b1;
    in0_msg = 32'h4000_0000;
    in1_msg = 32'h4100_0000;
    while (n0 + n1 < 12) begin
      @(negedge clk);
      if (took0) begin
        n0++;
        in0_msg = 32'h4000_0000 + n0;
      end
      if (took1) begin
        n1++;
        in1_msg = 32'h4100_0000 + n1;
      end
    end
    in0_val = 1'b0;
    in1_val = 1'b0;
    wait_drained();
    finish_test();
  endtask

  task automatic random_traffic();
    logic [31:0] r;
    start_test("random_traffic");
    repeat (RAND_CYCLES) begin
      @(negedge clk);
      // A waiting producer keeps its message and an idle one draws anew
      if (!(in0_val && !took0)) begin
        rand_bits(1, r);
        in0_val = r[0];
        rand_bits(32, r);
        in0_msg = r;
      end
      if (!(in1_val && !took1)) begin
        rand_bits(1, r);
        in1_val = r[0];
        rand_bits(32, r);
        in1_msg = r;
      end
      rand_bits(1, r);
      out_rdy = r[0];
    end
    // Offers still pending stay up until the arbiter takes them
    out_rdy = 1'b1;
    while (in0_val || in1_val) begin
      @(negedge clk);
      if (took0) begin
        in0_val = 1'b0;
      end
      if (took1) begin
        in1_val = 1'b0;
      end
    end
    wait_drained();
    finish_test();
  endtask

  // ------------------------------------------------------------
  // Run control
  // ------------------------------------------------------------

  initial begin : main
    reset      = 1'b0;
    in0_val    = 1'b0;
    in0_msg    = '0;
    in1_val    = 1'b0;
    in1_msg    = '0;
    out_rdy    = 1'b0;
    lfsr_state = LFSR_SEED;
    cur_test   = "reset";
    err_count  = 0;
    pass_tests = 0;
    fail_tests = 0;
    apply_reset();
    check_reset_state();
    single_domain_order();
    fill_and_drain();
    round_robin_merge();
    random_traffic();
    $display("tests passed %0d, failed %0d, check errors %0d",
             pass_tests, fail_tests, err_count);
    if (fail_tests == 0 && err_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // Stops a run that never reaches the end of the tests
  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout after %0d cycles, test %s did not finish", cycle_count, cur_test);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule
